// File: verilog/cam_usb_pkg.sv
`default_nettype none

package cam_usb_pkg;

  // ========================================
  // camera and pixel sizes
  // ========================================
  localparam int CAM_BYTE_W = 8;                     // camera bus
  localparam int PIXEL_W    = 16;                    // two bytes per pixel

  // ========================================
  // byte FIFO
  // ========================================
  localparam int BYTE_FIFO_DEPTH    = 2048;          // bytes
  localparam int FIFO_CNT_W         = 12;            // 0..2048
  localparam int FIFO_ADDR_W        = 11;            // byte pointer width
  localparam int ALMOST_FULL_MARGIN = 16;            // free bytes kept in reserve

  // ========================================
  // USB bulk side
  // ========================================
  localparam int PKT_BYTES = 512;                    // fixed bulk packet
  localparam int PKT_CNT_W = 9;                      // 0..511 pops inside a packet

  localparam int HEARTBEAT_HALF_DEFAULT = 30_000_000; // half second at 60 MHz

  typedef enum logic [1:0] {
    FEED_IDLE  = 2'd0,                               // waiting for a full packet
    FEED_BURST = 2'd1                                // packet in progress
  } feeder_state_t;

endpackage

`default_nettype wire

// File: verilog/pixel_capture.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_capture
  import cam_usb_pkg::*;
(
  input  wire logic                  ulpi_clk,
  input  wire logic                  I_rst_n,
  input  wire logic                  cam_vsync_i,
  input  wire logic                  cam_href_i,
  input  wire logic [CAM_BYTE_W-1:0] cam_data_i,
  input  wire logic                  pix_ready_i,
  output logic                       pix_valid_o,
  output logic [PIXEL_W-1:0]         pix_data_o
);

  // ========================================
  // byte pairing
  // ========================================
  logic                  phase_q;                    // 1 = high byte already held
  logic [CAM_BYTE_W-1:0] hi_byte_q;                  // first byte of the pair
  logic                  byte_en;                    // camera byte this cycle
  logic                  pair_done;                  // second byte of a pair

  assign byte_en   = cam_href_i & ~cam_vsync_i;      // vsync wins over href
  assign pair_done = byte_en & phase_q;

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      phase_q <= 1'b0;
    end else if (cam_vsync_i) begin
      phase_q <= 1'b0;                               // frame starts on a pixel boundary
    end else if (byte_en) begin
      phase_q <= ~phase_q;
    end
  end

  // high byte register, payload only
  always_ff @(posedge ulpi_clk) begin
    if (byte_en && !phase_q) begin
      hi_byte_q <= cam_data_i;
    end
  end

  // ========================================
  // pixel output
  // ========================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      pix_valid_o <= 1'b0;
    end else if (pair_done) begin
      pix_valid_o <= 1'b1;                           // one cycle after 2nd byte
    end else if (pix_valid_o && pix_ready_i) begin
      pix_valid_o <= 1'b0;                           // taken by the FIFO
    end else if (pix_valid_o) begin
      pix_valid_o <= 1'b0;                           // refused, pixel is lost
    end
  end

  // first byte of the pair goes high
  always_ff @(posedge ulpi_clk) begin
    if (pair_done) begin
      pix_data_o <= {hi_byte_q, cam_data_i};
    end
  end

endmodule

`default_nettype wire

// File: verilog/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
  import cam_usb_pkg::*;
(
  input  wire logic                  ulpi_clk,
  input  wire logic                  I_rst_n,
  input  wire logic                  push_valid_i,
  input  wire logic [PIXEL_W-1:0]    push_data_i,
  output logic                       push_ready_o,
  input  wire logic                  pop_i,
  output logic [CAM_BYTE_W-1:0]      head_o,
  output logic [FIFO_CNT_W-1:0]      count_o
);

  // ========================================
  // storage
  // ========================================
  // pushes always land on an even byte address, so the byte memory is
  // split into a high-byte bank and a low-byte bank, one write port each
  localparam int BANK_DEPTH = BYTE_FIFO_DEPTH / 2;

  logic [CAM_BYTE_W-1:0] mem_hi [BANK_DEPTH];        // even byte addresses
  logic [CAM_BYTE_W-1:0] mem_lo [BANK_DEPTH];        // odd byte addresses

  logic [FIFO_ADDR_W-1:0] wr_ptr_q;                  // byte pointer, bit 0 stays 0
  logic [FIFO_ADDR_W-1:0] rd_ptr_q;                  // byte pointer
  logic [FIFO_CNT_W-1:0]  count_q;

  logic push;
  logic pop;

  // almost-full rule
  assign push_ready_o = (count_q <= FIFO_CNT_W'(BYTE_FIFO_DEPTH - ALMOST_FULL_MARGIN));
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_i & (count_q != '0);     // never underflow

  always_ff @(posedge ulpi_clk) begin
    if (push) begin
      mem_hi[wr_ptr_q[FIFO_ADDR_W-1:1]] <= push_data_i[PIXEL_W-1:CAM_BYTE_W];
      mem_lo[wr_ptr_q[FIFO_ADDR_W-1:1]] <= push_data_i[CAM_BYTE_W-1:0];
    end
  end

  // ========================================
  // pointers and count
  // ========================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + FIFO_ADDR_W'(2);      // two bytes per pixel
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + FIFO_ADDR_W'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + FIFO_CNT_W'(2);
        2'b01:   count_q <= count_q - FIFO_CNT_W'(1);
        2'b11:   count_q <= count_q + FIFO_CNT_W'(1); // +2 -1
        default: count_q <= count_q;
      endcase
    end
  end

  // ========================================
  // first-word-fall-through read
  // ========================================
  always_comb begin
    if (rd_ptr_q[0]) begin
      head_o = mem_lo[rd_ptr_q[FIFO_ADDR_W-1:1]];   // odd byte, low half
    end else begin
      head_o = mem_hi[rd_ptr_q[FIFO_ADDR_W-1:1]];   // even byte, high half
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

// File: verilog/usb_bulk_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_feeder
  import cam_usb_pkg::*;
(
  input  wire logic                  ulpi_clk,
  input  wire logic                  I_rst_n,
  input  wire logic                  usb_online_i,
  input  wire logic                  usb_txpop_i,
  input  wire logic [FIFO_CNT_W-1:0] fifo_count_i,
  input  wire logic [CAM_BYTE_W-1:0] fifo_head_i,
  output logic                       fifo_pop_o,
  output logic [CAM_BYTE_W-1:0]      usb_txdat_o,
  output logic                       usb_txcork_o
);

  feeder_state_t         state_q;
  logic [PKT_CNT_W-1:0]  pkt_cnt_q;                  // pops done in this packet
  logic                  pkt_avail;                  // full packet buffered, online
  logic                  pkt_next;                   // another one left after last pop
  logic                  pop_ok;
  logic                  last_pop;

  assign pkt_avail = usb_online_i & (fifo_count_i >= FIFO_CNT_W'(PKT_BYTES));
  assign pkt_next  = usb_online_i & (fifo_count_i >= FIFO_CNT_W'(PKT_BYTES + 1));
  assign pop_ok    = usb_txpop_i & ~usb_txcork_o;    // corked pops are ignored
  assign last_pop  = pop_ok & (pkt_cnt_q == PKT_CNT_W'(PKT_BYTES - 1));

  // ========================================
  // cork FSM
  // ========================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state_q      <= FEED_IDLE;
      pkt_cnt_q    <= '0;
      usb_txcork_o <= 1'b1;                          // hold the endpoint
    end else begin
      case (state_q)
        FEED_IDLE: begin
          usb_txcork_o <= ~pkt_avail;                // falls one cycle later
          if (pop_ok && usb_online_i) begin
            state_q      <= FEED_BURST;              // first byte of packet
            pkt_cnt_q    <= PKT_CNT_W'(1);
            usb_txcork_o <= 1'b0;
          end
        end
        FEED_BURST: begin
          if (!usb_online_i) begin
            state_q      <= FEED_IDLE;               // host went away
            pkt_cnt_q    <= '0;
            usb_txcork_o <= 1'b1;
          end else if (last_pop) begin
            state_q      <= FEED_IDLE;
            pkt_cnt_q    <= '0;
            usb_txcork_o <= ~pkt_next;               // stay open if more is ready
          end else if (pop_ok) begin
            pkt_cnt_q <= pkt_cnt_q + PKT_CNT_W'(1);
          end
        end
        default: begin
          state_q      <= FEED_IDLE;
          pkt_cnt_q    <= '0;
          usb_txcork_o <= 1'b1;
        end
      endcase
    end
  end

  // ========================================
  // data path to controller
  // ========================================
  assign fifo_pop_o  = pop_ok;
  assign usb_txdat_o = fifo_head_i;                  // FWFT head, no register

endmodule

`default_nettype wire

// File: verilog/heartbeat_div.sv
`timescale 1ns/1ps
`default_nettype none

module heartbeat_div
  import cam_usb_pkg::*;
#(
  parameter int unsigned HEARTBEAT_HALF = HEARTBEAT_HALF_DEFAULT
) (
  input  wire logic ulpi_clk,
  input  wire logic I_rst_n,
  output logic      heartbeat_o
);

  logic [31:0] div_cnt_q;                            // up to ~4.29e9 cycles
  logic        wrap;

  assign wrap = (div_cnt_q == 32'(HEARTBEAT_HALF - 1));

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      div_cnt_q   <= '0;
      heartbeat_o <= 1'b0;
    end else if (wrap) begin
      div_cnt_q   <= '0;
      heartbeat_o <= ~heartbeat_o;                   // one toggle per half period
    end else begin
      div_cnt_q <= div_cnt_q + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cam_usb_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_usb_top
  import cam_usb_pkg::*;
#(
  parameter int unsigned HEARTBEAT_HALF = HEARTBEAT_HALF_DEFAULT
) (
  input  wire logic                  ulpi_clk,
  input  wire logic                  I_rst_n,
  input  wire logic                  cam_vsync_i,
  input  wire logic                  cam_href_i,
  input  wire logic [CAM_BYTE_W-1:0] cam_data_i,
  input  wire logic                  usb_online_i,
  input  wire logic                  usb_txpop_i,
  output logic [CAM_BYTE_W-1:0]      usb_txdat_o,
  output logic                       usb_txcork_o,
  output logic                       heartbeat_o
);

  // ========================================
  // capture to FIFO
  // ========================================
  logic                  pix_valid;
  logic [PIXEL_W-1:0]    pix_data;
  logic                  pix_ready;

  // FIFO to feeder
  logic [CAM_BYTE_W-1:0] fifo_head;
  logic [FIFO_CNT_W-1:0] fifo_count;
  logic                  fifo_pop;

  pixel_capture u_capture (
    .ulpi_clk    (ulpi_clk),
    .I_rst_n     (I_rst_n),
    .cam_vsync_i (cam_vsync_i),
    .cam_href_i  (cam_href_i),
    .cam_data_i  (cam_data_i),
    .pix_ready_i (pix_ready),
    .pix_valid_o (pix_valid),
    .pix_data_o  (pix_data)
  );

  byte_fifo u_fifo (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .push_valid_i (pix_valid),
    .push_data_i  (pix_data),
    .push_ready_o (pix_ready),
    .pop_i        (fifo_pop),
    .head_o       (fifo_head),
    .count_o      (fifo_count)
  );

  // ========================================
  // USB side
  // ========================================
  usb_bulk_feeder u_feeder (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .usb_online_i (usb_online_i),
    .usb_txpop_i  (usb_txpop_i),
    .fifo_count_i (fifo_count),
    .fifo_head_i  (fifo_head),
    .fifo_pop_o   (fifo_pop),
    .usb_txdat_o  (usb_txdat_o),
    .usb_txcork_o (usb_txcork_o)
  );

  heartbeat_div #(
    .HEARTBEAT_HALF (HEARTBEAT_HALF)
  ) u_heartbeat (
    .ulpi_clk    (ulpi_clk),
    .I_rst_n     (I_rst_n),
    .heartbeat_o (heartbeat_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_cam_usb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cam_usb_top
  import cam_usb_pkg::*;
;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 8;
  localparam int          HB_HALF      = 100;           // heartbeat half period, cycles
  localparam logic [31:0] RNG_SEED     = 32'he5c1721a;
  localparam int          OVF_KEPT     = BYTE_FIFO_DEPTH - ALMOST_FULL_MARGIN + 2;
  localparam int          TOPUP_PIX    = (PKT_BYTES - (OVF_KEPT % PKT_BYTES)) / 2;
  // watchdog budget per phase, in cycles
  localparam int          WATCHDOG_CYCLES = 40 + 3000 + 5000 + 2500 + 2000;

  logic                  ulpi_clk = 1'b0;
  logic                  I_rst_n;
  logic                  cam_vsync_i;
  logic                  cam_href_i;
  logic [CAM_BYTE_W-1:0] cam_data_i;
  logic                  usb_online_i;
  logic                  usb_txpop_i;
  logic [CAM_BYTE_W-1:0] usb_txdat_o;
  logic                  usb_txcork_o;
  logic                  heartbeat_o;

  // scoreboard and models
  logic [CAM_BYTE_W-1:0] sb_q[$];                     // bytes expected at the USB side
  logic [CAM_BYTE_W-1:0] exp_head;                    // front of queue for this edge
  logic [CAM_BYTE_W-1:0] dat_seen;                    // usb_txdat_o for this edge
  logic [CAM_BYTE_W-1:0] hi_byte;
  logic [CAM_BYTE_W-1:0] pend_hi;
  logic [CAM_BYTE_W-1:0] pend_lo;
  logic                  pend_valid;                  // pixel offered at next edge
  logic                  phase;
  logic                  pop_acc;                     // pop taken at next edge
  logic                  sb_empty;
  logic                  hb_now;
  logic                  hb_prev;
  logic                  hb_armed;
  logic [31:0]           rng_state;
  int                    model_count;                 // bytes after next edge
  int                    cnt_seen;                    // bytes before next edge
  int                    pop_total;
  int                    pkt_pops;                    // pops inside current packet
  int                    hb_cycles;                   // edges since reset release
  int                    cyc;
  int                    ovf_start;
  int                    offl_start;

  cam_usb_top #(
    .HEARTBEAT_HALF (HB_HALF)
  ) dut0 (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .cam_vsync_i  (cam_vsync_i),
    .cam_href_i   (cam_href_i),
    .cam_data_i   (cam_data_i),
    .usb_online_i (usb_online_i),
    .usb_txpop_i  (usb_txpop_i),
    .usb_txdat_o  (usb_txdat_o),
    .usb_txcork_o (usb_txcork_o),
    .heartbeat_o  (heartbeat_o)
  );

  always #(CLK_PERIOD / 2) ulpi_clk = ~ulpi_clk;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ========================================
  // models, sampled mid-cycle
  // ========================================
  always @(negedge ulpi_clk) begin
    cyc     = cyc + 1;
    hb_prev = hb_now;
    hb_now  = heartbeat_o;
    if (!I_rst_n) begin
      sb_q.delete();
      pend_valid  = 1'b0;
      phase       = 1'b0;
      pop_acc     = 1'b0;
      hb_armed    = 1'b0;
      hb_cycles   = 0;
      model_count = 0;
      pkt_pops    = 0;
    end else begin
      if (hb_armed) hb_cycles = hb_cycles + 1;        // first edge after release not yet seen
      hb_armed = 1'b1;
      cnt_seen = model_count;
      pop_acc  = usb_txpop_i && !usb_txcork_o;        // corked pops ignored
      dat_seen = usb_txdat_o;
      sb_empty = (sb_q.size() == 0);
      exp_head = sb_empty ? '0 : sb_q[0];
      if (pop_acc && !sb_empty) begin
        void'(sb_q.pop_front());
        model_count = model_count - 1;
        pop_total   = pop_total + 1;
        pkt_pops    = (pkt_pops + 1) % PKT_BYTES;
      end
      // almost-full rule, whole pixel dropped
      if (pend_valid && cnt_seen <= BYTE_FIFO_DEPTH - ALMOST_FULL_MARGIN) begin
        sb_q.push_back(pend_hi);
        sb_q.push_back(pend_lo);
        model_count = model_count + 2;
      end
      pend_valid = 1'b0;
      if (cam_vsync_i) begin
        phase = 1'b0;                                 // odd byte discarded
      end else if (cam_href_i) begin
        if (phase) begin
          pend_valid = 1'b1;
          pend_hi    = hi_byte;
          pend_lo    = cam_data_i;
        end else begin
          hi_byte = cam_data_i;
        end
        phase = !phase;
      end
    end
  end

  // ========================================
  // checkers
  // ========================================
  a_reset_state: assert property (@(posedge ulpi_clk)
      (cyc >= 1 && (!I_rst_n || $rose(I_rst_n))) |-> (usb_txcork_o && !heartbeat_o))
    else stop_on_error("cork low or heartbeat high in reset");

  a_byte_order: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
      pop_acc |-> (dat_seen == exp_head))
    else stop_on_error($sformatf("CHECK FAILED usb_txdat_o got 0x%02h expected 0x%02h",
                                 dat_seen, exp_head));

  a_pop_empty: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
      pop_acc |-> !sb_empty)
    else stop_on_error("pop accepted while no byte was buffered");

  a_cork_fall: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
      $fell(usb_txcork_o) |-> $past(cnt_seen >= PKT_BYTES && usb_online_i))
    else stop_on_error("cork fell without a full packet buffered and online");

  a_cork_rise: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
      ($rose(usb_txcork_o) && $past(usb_online_i)) |-> (pkt_pops == 0))
    else stop_on_error($sformatf("cork rose after %0d pops into a packet", pkt_pops));

  a_offline: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
      $past(!usb_online_i) |-> usb_txcork_o)
    else stop_on_error("cork released while the device was offline");

  a_heartbeat: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
      (hb_cycles != 0) |-> ((hb_now != hb_prev) == (hb_cycles % HB_HALF == 0)))
    else stop_on_error($sformatf("CHECK FAILED heartbeat_o was 0x%0h now 0x%0h at cycle 0x%0h",
                                 hb_prev, hb_now, hb_cycles));

  // ========================================
  // stimulus
  // ========================================
  task automatic next_cycle();
    @(posedge ulpi_clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  // one camera line, npix pixels plus an optional odd byte
  task automatic send_line(input int npix, input bit odd);
    for (int i = 0; i < 2 * npix + int'(odd); i++) begin
      next_cycle();
      rng_state  = xorshift32(rng_state);
      cam_href_i = 1'b1;
      cam_data_i = rng_state[CAM_BYTE_W-1:0];
    end
    next_cycle();
    cam_href_i = 1'b0;
    cam_data_i = '0;
  endtask

  task automatic pulse_vsync();
    next_cycle();
    cam_vsync_i = 1'b1;
    idle(2);
    cam_vsync_i = 1'b0;
  endtask

  // gives up after max_cycles edges, the caller checks the total
  task automatic wait_pops(input int target, input int max_cycles);
    int n;
    n = 0;
    while (pop_total < target && n < max_cycles) begin
      @(negedge ulpi_clk);
      n = n + 1;
    end
  endtask

  task automatic wait_empty();
    while (model_count != 0) @(negedge ulpi_clk);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error("watchdog expired before the tests finished");
  end

  initial begin
    I_rst_n      = 1'b0;
    cam_vsync_i  = 1'b0;
    cam_href_i   = 1'b0;
    cam_data_i   = '0;
    usb_online_i = 1'b0;
    usb_txpop_i  = 1'b1;                              // pops while corked
    rng_state    = RNG_SEED;
    cyc          = 0;
    pop_total    = 0;
    repeat (RESET_CYCLES) @(posedge ulpi_clk);
    #1;
    I_rst_n      = 1'b1;
    usb_online_i = 1'b1;
    idle(20);                                         // empty FIFO, pops ignored

    // byte order and packet framing, pops always on
    send_line(0, 1'b1);                               // lone byte before vsync
    pulse_vsync();
    send_line(200, 1'b0);
    idle(20);                                         // 400 bytes, cork holds
    send_line(100, 1'b0);
    send_line(300, 1'b1);                             // odd byte at end of line
    pulse_vsync();
    send_line(100, 1'b0);
    send_line(68, 1'b0);
    wait_empty();

    // overflow with the controller stalled
    next_cycle();
    usb_txpop_i = 1'b0;
    send_line(1200, 1'b0);
    idle(5);
    ovf_start   = pop_total;
    usb_txpop_i = 1'b1;
    wait_pops(ovf_start + 3 * PKT_BYTES, 4 * PKT_BYTES);
    idle(20);
    assert (pop_total - ovf_start == 3 * PKT_BYTES)
      else stop_on_error("overflow data not drained as whole packets");
    send_line(TOPUP_PIX, 1'b0);                       // completes the last packet
    wait_pops(ovf_start + OVF_KEPT + 2 * TOPUP_PIX, 2 * PKT_BYTES);
    assert (pop_total - ovf_start == OVF_KEPT + 2 * TOPUP_PIX)
      else stop_on_error($sformatf("CHECK FAILED delivered bytes 0x%0h expected 0x%0h",
                                   pop_total - ovf_start, OVF_KEPT + 2 * TOPUP_PIX));

    // offline hold
    next_cycle();
    usb_online_i = 1'b0;
    send_line(300, 1'b0);
    idle(50);
    offl_start   = pop_total;
    usb_online_i = 1'b1;
    wait_pops(offl_start + PKT_BYTES, 2 * PKT_BYTES);
    send_line(212, 1'b0);
    wait_empty();
    idle(10);

    if (sb_q.size() != 0 || model_count != 0) begin
      stop_on_error("bytes left in the scoreboard at the end of the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: cam_usb_stream.f
verilog/cam_usb_pkg.sv
verilog/pixel_capture.sv
verilog/byte_fifo.sv
verilog/usb_bulk_feeder.sv
verilog/heartbeat_div.sv
verilog/cam_usb_top.sv
sim/tb_cam_usb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the camera to USB stream testbench with Verilator, run it,
# and decide pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim_run.log
TOP=tb_cam_usb_top

verilator --binary --assert --timing -j 0 \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP" \
  -f cam_usb_stream.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -qx '\*\* PASS \*\*' "$LOG_FILE"; then
  exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
